// ==== src/switch_defines.svh ====
`ifndef SWITCH_DEFINES_SVH
`define SWITCH_DEFINES_SVH

// number of switch ports, 2, 4 or 8
`define SWITCH_PORTS 4

// one flit word, header fields plus zero padding
`define SWITCH_FLIT_W 16

// longest burst a source may draw
`define SWITCH_MAX_BURST 10

`define SWITCH_LFSR_W 8

`endif

// ==== src/switch_pkg.sv ====
`include "switch_defines.svh"

package switch_pkg;

    localparam int PORT_W = (`SWITCH_PORTS > 1) ? $clog2(`SWITCH_PORTS) : 1;

    typedef logic [PORT_W-1:0] port_idx_t;

    typedef logic [3:0] burst_len_t;   // holds 0 up to the burst limit

    localparam int PAD_W = `SWITCH_FLIT_W - 2 * PORT_W - $bits(burst_len_t);

    // header layout, seq sits in the low bits
    typedef struct packed {
        logic [PAD_W-1:0] pad;
        port_idx_t        src;
        port_idx_t        dst;
        burst_len_t       seq;
    } flit_fields_t;

    // the arbiter only moves raw words, the sources fill in fields
    typedef union packed {
        logic [`SWITCH_FLIT_W-1:0] raw;
        flit_fields_t              fields;
    } flit_u;

endpackage

// ==== src/start_sequencer.sv ====
`timescale 1ns/1ps
`include "switch_defines.svh"

module start_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  logic [`SWITCH_PORTS-1:0] cmd_mask,
    input  logic [`SWITCH_PORTS-1:0] busy,
    input  logic [`SWITCH_PORTS-1:0] done,
    output logic [`SWITCH_PORTS-1:0] start,
    output logic                     all_done
);

    localparam int N = `SWITCH_PORTS;

    logic [N-1:0] pending;      // requested but not yet started
    logic [N-1:0] waiting;      // commanded and no done seen since
    logic [N-1:0] new_req;
    logic         commanded;

    assign new_req = cmd_valid ? cmd_mask : '0;

    // a request for a running source stays here until that source goes idle
    assign start = pending & ~busy;

    // **************************************************
    // request bookkeeping
    // **************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= '0;
            waiting   <= '0;
            commanded <= 1'b0;
        end else begin
            pending <= (pending & ~start) | new_req;
            // a done while a further request is still pending ends nothing
            waiting <= (waiting & ~(done & ~pending)) | new_req;   // a new command wins over done
            if (cmd_valid) begin
                commanded <= 1'b1;
            end
        end
    end

    // waiting adds one cycle after the last done so the final
    // registered output flit is out before all_done rises
    assign all_done = commanded && !(|pending) && !(|busy) && !(|waiting);

endmodule

// ==== src/burst_source.sv ====
`timescale 1ns/1ps
`include "switch_defines.svh"

module burst_source #(
    parameter int src_id = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              stall,
    output logic              valid,
    output logic              busy,
    output logic              done,
    output switch_pkg::flit_u flit
);
    import switch_pkg::*;

    localparam int LW = `SWITCH_LFSR_W;
    localparam logic [LW-1:0] SEED = LW'(src_id * 37 + 1);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] RUN  = 2'd1;
    localparam logic [1:0] DONE = 2'd2;

    logic [1:0]    state;
    logic [1:0]    state_n;
    logic [LW-1:0] lfsr;
    logic [LW-1:0] lfsr_next;
    logic [3:0]    draw;
    burst_len_t    draw_len;
    burst_len_t    remain;        // flits still to send, current one included
    burst_len_t    seq;
    port_idx_t     dst;
    logic          load;
    logic          step;

    // a start is also taken in DONE so back-to-back bursts lose no cycle
    assign load = start && (state != RUN);
    assign step = (state == RUN) && !stall;

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_next = {lfsr[LW-2:0], lfsr[LW-1] ^ lfsr[LW-3] ^ lfsr[LW-4] ^ lfsr[LW-5]};

    assign draw     = lfsr[LW-1 -: 4];
    assign draw_len = burst_len_t'(draw % `SWITCH_MAX_BURST + 1);

    // **************************************************
    // burst FSM
    // **************************************************

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_n = RUN;
                end
            end
            RUN: begin
                if (step && remain == burst_len_t'(1)) begin
                    state_n = DONE;
                end
            end
            DONE: begin
                state_n = start ? RUN : IDLE;
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            lfsr   <= SEED;
            remain <= '0;
        end else begin
            state <= state_n;
            if (load) begin
                lfsr   <= lfsr_next;   // one step per burst
                remain <= draw_len;
            end else if (step) begin
                remain <= remain - 1'b1;
            end
        end
    end

    // destination and sequence only matter while valid is high
    always_ff @(posedge clk) begin
        if (load) begin
            dst <= port_idx_t'(lfsr);
            seq <= '0;
        end else if (step) begin
            seq <= seq + 1'b1;
        end
    end

    assign valid = (state == RUN);
    assign busy  = (state == RUN);
    assign done  = (state == DONE);

    always_comb begin
        flit            = '0;
        flit.fields.src = port_idx_t'(src_id);
        flit.fields.dst = dst;
        flit.fields.seq = seq;
    end

endmodule

// ==== src/output_arbiter.sv ====
`timescale 1ns/1ps
`include "switch_defines.svh"

module output_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`SWITCH_PORTS-1:0] src_valid,
    input  switch_pkg::flit_u        src_flit [`SWITCH_PORTS],
    output logic [`SWITCH_PORTS-1:0] stall,
    output logic [`SWITCH_PORTS-1:0] out_valid,
    output switch_pkg::flit_u        out_flit [`SWITCH_PORTS]
);
    import switch_pkg::*;

    localparam int N = `SWITCH_PORTS;

    logic [N-1:0] req [N];      // req[o][s] means source s asks for output o
    logic [N-1:0] hit;          // output has a winner this cycle
    logic [N-1:0] granted;      // per source
    port_idx_t    ptr [N];
    port_idx_t    win [N];

    always_comb begin
        for (int o = 0; o < N; o++) begin
            for (int s = 0; s < N; s++) begin
                req[o][s] = src_valid[s] && (src_flit[s].fields.dst == port_idx_t'(o));
            end
        end
    end

    // **************************************************
    // round-robin choice per output
    // **************************************************

    always_comb begin
        port_idx_t idx;
        hit     = '0;
        granted = '0;
        for (int o = 0; o < N; o++) begin
            win[o] = ptr[o];
            for (int k = 0; k < N; k++) begin
                idx = port_idx_t'(ptr[o] + k);   // wraps around the port count
                if (!hit[o] && req[o][idx]) begin
                    hit[o] = 1'b1;
                    win[o] = idx;
                end
            end
            if (hit[o]) begin
                granted[win[o]] = 1'b1;
            end
        end
    end

    // a source asks for one output only, so not granted means it lost
    assign stall = src_valid & ~granted;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
            for (int o = 0; o < N; o++) begin
                ptr[o] <= '0;
            end
        end else begin
            out_valid <= hit;
            for (int o = 0; o < N; o++) begin
                if (hit[o]) begin
                    ptr[o] <= win[o] + 1'b1;   // next search starts past the winner
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < N; o++) begin
            if (hit[o]) begin
                out_flit[o].raw <= src_flit[win[o]].raw;
            end
        end
    end

endmodule

// ==== src/switch_top.sv ====
`timescale 1ns/1ps
`include "switch_defines.svh"

module switch_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  logic [`SWITCH_PORTS-1:0] cmd_mask,
    output logic [`SWITCH_PORTS-1:0] out_valid,
    output switch_pkg::flit_u        out_flit [`SWITCH_PORTS],
    output logic                     all_done
);
    import switch_pkg::*;

    logic [`SWITCH_PORTS-1:0] start;
    logic [`SWITCH_PORTS-1:0] busy;
    logic [`SWITCH_PORTS-1:0] done;
    logic [`SWITCH_PORTS-1:0] src_valid;
    logic [`SWITCH_PORTS-1:0] stall;
    flit_u                    src_flit [`SWITCH_PORTS];

    start_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_mask  (cmd_mask),
        .busy      (busy),
        .done      (done),
        .start     (start),
        .all_done  (all_done)
    );

    // one source per port, src_id doubles as the LFSR seed selector
    for (genvar i = 0; i < `SWITCH_PORTS; i++) begin : g_src
        burst_source #(
            .src_id (i)
        ) u_src (
            .clk   (clk),
            .rst_n (rst_n),
            .start (start[i]),
            .stall (stall[i]),
            .valid (src_valid[i]),
            .busy  (busy[i]),
            .done  (done[i]),
            .flit  (src_flit[i])
        );
    end

    output_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_valid (src_valid),
        .src_flit  (src_flit),
        .stall     (stall),
        .out_valid (out_valid),
        .out_flit  (out_flit)
    );

endmodule

// ==== testbench/tb_switch_top.sv ====
`timescale 1ns/1ps
`include "switch_defines.svh"

module tb_switch_top;
    import switch_pkg::*;

    localparam int N        = `SWITCH_PORTS;
    localparam int NUM_CMDS = 8;
    localparam int WATCHDOG = NUM_CMDS * N * `SWITCH_MAX_BURST * N + 200;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         cmd_valid;
    logic [N-1:0] cmd_mask;
    logic [N-1:0] out_valid;
    flit_u        out_flit [N];
    logic         all_done;

    logic [7:0]   stim_mem [3*NUM_CMDS];         // flag, mask, total for each command
    logic [N-1:0] active_mask  = '0;
    int           issued [N]   = '{default: 0};  // bursts commanded per source
    int           rx_burst [N] = '{default: 0};  // bursts fully seen per source
    int           rx_seq [N]   = '{default: 0};
    int           flit_count   = 0;

    switch_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_mask  (cmd_mask),
        .out_valid (out_valid),
        .out_flit  (out_flit),
        .all_done  (all_done)
    );

    always #4 clk = ~clk;

    // **************************************************
    // reference model of the source LFSRs
    // **************************************************

    // x^8+x^6+x^5+x^4+1 shifted left with the feedback in bit 0
    function automatic logic [7:0] lfsr_after(int src, int draws);
        logic [7:0] s;
        s = 8'(src * 37 + 1);
        for (int i = 0; i < draws; i++) begin
            s = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
        end
        return s;
    endfunction

    function automatic int burst_len(int src, int draw);
        logic [7:0] s;
        s = lfsr_after(src, draw);
        return int'(s[7:4]) % `SWITCH_MAX_BURST + 1;
    endfunction

    function automatic port_idx_t burst_dst(int src, int draw);
        logic [7:0] s;
        s = lfsr_after(src, draw);
        return port_idx_t'(s);
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_flit(string name, flit_u exp, flit_u act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp.raw, act.raw);
            abort_run();
        end
    endtask

    task automatic check_port(string name, port_idx_t exp, port_idx_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic send_command(logic [N-1:0] mask);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_mask  <= mask;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_all_done();
        do begin
            @(negedge clk);
        end while (all_done !== 1'b1);
        @(posedge clk);   // the monitor has taken the flits of that negedge by now
    endtask

    task automatic close_group(int expected, int base);
        check_count("flits counted at all_done", expected, flit_count - base);
        for (int s = 0; s < N; s++) begin
            check_count($sformatf("bursts finished by source %0d", s), issued[s], rx_burst[s]);
            check_count($sformatf("seq position of source %0d", s), 0, rx_seq[s]);
        end
    endtask

    // **************************************************
    // output monitor sampled mid-cycle
    // **************************************************

    always @(negedge clk) begin
        logic [N-1:0] seen;
        int           s;
        int           len;
        flit_u        exp;
        seen = '0;   // a source shows up on one port per cycle at most
        for (int p = 0; p < N; p++) begin
            if (out_valid[p] === 1'b1) begin
                s = int'(out_flit[p].fields.src);
                if (seen[s] || !active_mask[s] || rx_burst[s] >= issued[s]) begin
                    $display("Source %0d showed a flit on port %0d that it was not due to send",
                             s, p);
                    abort_run();
                end
                seen[s] = 1'b1;
                check_port($sformatf("out_flit[%0d].fields.dst", p), port_idx_t'(p),
                           out_flit[p].fields.dst);
                len            = burst_len(s, rx_burst[s]);
                exp            = '0;
                exp.fields.src = port_idx_t'(s);
                exp.fields.dst = burst_dst(s, rx_burst[s]);
                exp.fields.seq = burst_len_t'(rx_seq[s]);
                check_flit($sformatf("out_flit[%0d]", p), exp, out_flit[p]);
                flit_count = flit_count + 1;
                if (rx_seq[s] == len - 1) begin
                    rx_burst[s] = rx_burst[s] + 1;   // next flit of s opens a new burst
                    rx_seq[s]   = 0;
                end else begin
                    rx_seq[s] = rx_seq[s] + 1;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG);
        abort_run();
    end

    initial begin
        int           flag;
        int           total;
        int           model_total;
        int           group_total;
        int           base;
        logic [N-1:0] mask;
        rst_n       <= 1'b0;
        cmd_valid   <= 1'b0;
        cmd_mask    <= '0;
        group_total = 0;
        base        = 0;
        $readmemh("testbench/switch_stim.txt", stim_mem);
        if ($isunknown(stim_mem[3*NUM_CMDS-1])) begin
            $display("The stim file is missing or holds fewer than %0d commands", NUM_CMDS);
            abort_run();
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) begin   // nothing may move before the first command
            @(negedge clk);
            check_count("all_done", 0, int'(all_done));
            check_count("out_valid", 0, int'(out_valid));
        end

        for (int k = 0; k < NUM_CMDS; k++) begin
            flag  = int'(stim_mem[3*k]);
            mask  = stim_mem[3*k+1][N-1:0];
            total = int'(stim_mem[3*k+2]);
            if (k > 0 && flag == 0) begin
                wait_all_done();
                close_group(group_total, base);
                group_total = 0;
                base        = flit_count;
                active_mask = '0;
            end
            model_total = 0;
            for (int s = 0; s < N; s++) begin
                if (mask[s]) begin
                    model_total = model_total + burst_len(s, issued[s]);
                    issued[s]   = issued[s] + 1;
                end
            end
            check_count($sformatf("stim total of command %0d", k), model_total, total);
            group_total = group_total + total;
            active_mask = active_mask | mask;
            send_command(mask);
        end
        wait_all_done();
        close_group(group_total, base);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== testbench/switch_stim.txt ====
// columns: no-wait flag, start mask, flits expected (all hex)
// a flag of 1 sends the command while the previous one is still running
0 f 11
0 4 0a
0 f 0e // sources 0 and 2 both head for port 2
0 3 0b
1 2 04 // source 1 is still in its long burst
0 f 11 // three sources share port 0
0 9 0b
0 6 06

// ==== vlog.f ====
+incdir+src
src/switch_pkg.sv
src/start_sequencer.sv
src/burst_source.sv
src/output_arbiter.sv
src/switch_top.sv
testbench/tb_switch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       ?= tb_switch_top
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run into $(LOG), look for the pass message"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
